// ==== project.f ====
bus_pkg.sv
work_ram.sv
rom_mapper.sv
zbus_arbiter.sv
main_bus_ctrl.sv
bus_system.sv
bus_system_asserts.sv
tb_clock.sv
bus_system_tb.sv

// ==== bus_system_tb.sv ====
// Testbench top with stimulus tasks, ROM responder model, checks and report
`timescale 1ns/1ns
`default_nettype none

module bus_system_tb;

	localparam int unsigned ROM_SIZE = 32'h40_0000;
	// Whole run needs a few hundred cycles
	localparam int TIMEOUT_CYCLES = 20000;

	logic                      MCLK;
	logic                      reset;
	logic                      m_as;
	logic [bus_pkg::MA_W:1]    m_addr;
	logic [bus_pkg::MD_W-1:0]  m_wdata;
	logic                      m_rnw;
	logic                      m_uds;
	logic                      m_lds;
	logic [bus_pkg::MD_W-1:0]  m_rdata;
	logic                      m_dtack;
	logic                      z_req;
	logic [15:0]               z_addr;
	logic [7:0]                z_wdata;
	logic                      z_wr;
	logic [7:0]                z_rdata;
	logic                      z_ack;
	logic [bus_pkg::ROM_AW:1]  rom_addr;
	logic [bus_pkg::MD_W-1:0]  rom_data;
	logic                      rom_req;
	logic                      rom_ack;
	logic                      z80_busreq;
	logic                      z80_reset_n;

	logic [23:0] last_rom_addr;
	int          cycle_count = 0;
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	int          errors_at_start = 0;

	tb_clock #(
		.PERIOD       (10),
		.RESET_CYCLES (2)
	) u_tb_clock (
		.MCLK  (MCLK),
		.reset (reset)
	);

	bus_system #(
		.ROM_SIZE (ROM_SIZE),
		.RAM_AW   (15)
	) u_bus_system (
		.MCLK        (MCLK),
		.reset       (reset),
		.m_as        (m_as),
		.m_addr      (m_addr),
		.m_wdata     (m_wdata),
		.m_rnw       (m_rnw),
		.m_uds       (m_uds),
		.m_lds       (m_lds),
		.m_rdata     (m_rdata),
		.m_dtack     (m_dtack),
		.z_req       (z_req),
		.z_addr      (z_addr),
		.z_wdata     (z_wdata),
		.z_wr        (z_wr),
		.z_rdata     (z_rdata),
		.z_ack       (z_ack),
		.rom_addr    (rom_addr),
		.rom_data    (rom_data),
		.rom_req     (rom_req),
		.rom_ack     (rom_ack),
		.z80_busreq  (z80_busreq),
		.z80_reset_n (z80_reset_n)
	);

	// ROM contents are the word address folded with a fixed pattern
	function automatic logic [15:0] rom_value(input logic [23:0] word_addr);
		return word_addr[15:0] ^ 16'hA5A5;
	endfunction

	// ------------------------------------------------------------------
	// ROM responder answers each toggle after a random delay
	// ------------------------------------------------------------------
	initial begin : rom_responder
		int unsigned wait_cycles;
		void'($urandom(69));
		rom_ack       = 1'b0;
		rom_data      = '0;
		last_rom_addr = '0;
		forever begin
			@(negedge MCLK);
			if (rom_req != rom_ack) begin
				wait_cycles = 1 + ($urandom % 6);
				repeat (wait_cycles) @(negedge MCLK);
				last_rom_addr = rom_addr;
				rom_data      = rom_value(rom_addr);
				rom_ack       = rom_req;
			end
		end
	end

	always @(posedge MCLK) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, an access was never acknowledged",
				cycle_count);
			$display("Regression failed");
			$finish;
		end
	end

	task automatic check_equal(input string what, input logic [23:0] got,
		input logic [23:0] exp);
		checks++;
		assert (got === exp)
		else begin
			$display("** Error at %0t ns: %s = %0h, expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic test_report(input string name);
		tests++;
		if (errors == errors_at_start)
			$display("Test %0d %s: ok", tests, name);
		else
			$display("Test %0d %s: FAILED, %0d errors", tests, name, errors - errors_at_start);
		errors_at_start = errors;
	endtask

	// ------------------------------------------------------------------
	// Main-CPU and sound-CPU access tasks
	// ------------------------------------------------------------------
	task automatic main_access(input logic [23:0] byte_addr, input logic rnw,
		input logic uds, input logic lds, input logic [15:0] wdata,
		output logic [15:0] rdata);
		@(negedge MCLK);
		m_addr  = byte_addr[23:1];
		m_wdata = wdata;
		m_rnw   = rnw;
		m_uds   = uds;
		m_lds   = lds;
		m_as    = 1'b1;
		do
			@(negedge MCLK);
		while (!m_dtack);
		rdata = m_rdata;
		m_as  = 1'b0;
	endtask

	task automatic main_write(input logic [23:0] byte_addr, input logic uds,
		input logic lds, input logic [15:0] wdata);
		logic [15:0] unused;
		main_access(byte_addr, 1'b0, uds, lds, wdata, unused);
	endtask

	task automatic main_read(input logic [23:0] byte_addr, output logic [15:0] rdata);
		main_access(byte_addr, 1'b1, 1'b1, 1'b1, 16'h0000, rdata);
	endtask

	task automatic sound_access(input logic [15:0] addr, input logic wr,
		input logic [7:0] wdata, output logic [7:0] rdata);
		@(negedge MCLK);
		z_addr  = addr;
		z_wr    = wr;
		z_wdata = wdata;
		z_req   = 1'b1;
		do
			@(negedge MCLK);
		while (!z_ack);
		rdata = z_rdata;
		z_req = 1'b0;
	endtask

	// ------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------
	initial begin : stimulus
		logic [15:0] rd16;
		logic [7:0]  rd8;
		logic [23:0] addr_b;
		int          total_errors;

		m_as    = 1'b0;
		m_addr  = '0;
		m_wdata = '0;
		m_rnw   = 1'b1;
		m_uds   = 1'b0;
		m_lds   = 1'b0;
		z_req   = 1'b0;
		z_addr  = '0;
		z_wdata = '0;
		z_wr    = 1'b0;
		wait (reset == 1'b0);

		// Lane writes keep the other byte
		main_write(24'hFF0000, 1'b1, 1'b1, 16'h1234);
		main_write(24'hFF0000, 1'b0, 1'b1, 16'h0056);
		main_read(24'hFF0000, rd16);
		check_equal("m_rdata", rd16, {16'h1234 >> 8, 8'h56});
		test_report("work RAM lanes");

		addr_b = 24'h000100;
		main_read(addr_b, rd16);
		check_equal("m_rdata", rd16, rom_value({1'b0, addr_b[23:1]}));
		check_equal("rom_addr", last_rom_addr, {1'b0, addr_b[23:1]});
		// Bank index 2 takes page 3
		main_write(24'hA130F5, 1'b0, 1'b1, 16'h0003);
		addr_b = 24'h100100;
		main_read(addr_b, rd16);
		check_equal("rom_addr", last_rom_addr, {1'b0, 5'd3, addr_b[18:1]});
		check_equal("m_rdata", rd16, rom_value({1'b0, 5'd3, addr_b[18:1]}));
		test_report("ROM and mapper");

		main_read(24'hA11100, rd16);
		check_equal("m_rdata", rd16, 16'h0100);
		main_write(24'hA11100, 1'b1, 1'b1, 16'h0100);
		check_equal("z80_busreq", z80_busreq, 1'b1);
		main_read(24'hA11100, rd16);
		check_equal("m_rdata", rd16, 16'h0000);
		main_write(24'hA11200, 1'b1, 1'b1, 16'h0100);
		check_equal("z80_reset_n", z80_reset_n, 1'b1);
		main_read(24'hA11200, rd16);
		check_equal("m_rdata", rd16, 16'h0100);
		test_report("sound-CPU control register");

		// Bus granted from the previous test
		main_write(24'hA00010, 1'b1, 1'b0, 16'h7E00);
		main_read(24'hA00010, rd16);
		check_equal("m_rdata", rd16, 16'h7E7E);
		main_write(24'hA11100, 1'b1, 1'b1, 16'h0000);
		check_equal("z80_busreq", z80_busreq, 1'b0);
		sound_access(16'h0010, 1'b0, 8'h00, rd8);
		check_equal("z_rdata", rd8, 8'h7E);
		main_read(24'hA00010, rd16);
		check_equal("m_rdata", rd16, 16'hFFFF);
		test_report("ZBUS from main bus");

		main_write(24'hFF8000, 1'b1, 1'b1, 16'hC3A9);
		repeat (9)
			sound_access(16'h6000, 1'b1, 8'h01, rd8);
		check_equal("bar", u_bus_system.bar, 9'h1FF);
		sound_access(16'h8000, 1'b0, 8'h00, rd8);
		check_equal("z_rdata", rd8, 8'hC3);
		sound_access(16'h8001, 1'b0, 8'h00, rd8);
		check_equal("z_rdata", rd8, 8'hA9);
		test_report("sound-CPU bank window");

		main_read(24'hA20000, rd16);
		check_equal("m_rdata", rd16, 16'h0000);
		// 7Fxx lands in the empty C000xx space
		sound_access(16'h7F20, 1'b0, 8'h00, rd8);
		check_equal("z_rdata", rd8, 8'h00);
		test_report("unmapped reads");

		repeat (4) @(negedge MCLK);
		total_errors = errors + u_bus_system.u_asserts.fail_count;
		$display("Tests: %0d, checks: %0d, check errors: %0d, assertion failures: %0d",
			tests, checks, errors, u_bus_system.u_asserts.fail_count);
		if (total_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
// Testbench clock and reset generator
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
	parameter int PERIOD       = 10,
	parameter int RESET_CYCLES = 2
) (
	output logic MCLK,
	output logic reset
);

	initial begin
		MCLK = 1'b0;
		forever
			#(PERIOD / 2) MCLK = ~MCLK;
	end

	// Release on a falling edge, like the rest of the stimulus
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge MCLK);
		@(negedge MCLK);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// ==== bus_system_asserts.sv ====
// Concurrent protocol assertions for bus_system and their bind
`timescale 1ns/1ns
`default_nettype none

module bus_system_asserts (
	input logic MCLK,
	input logic reset,
	input logic m_as,
	input logic m_dtack,
	input logic z_req,
	input logic z_ack,
	input logic rom_req,
	input logic rom_ack,
	input logic z80_busreq,
	input logic z80_reset_n
);

	int fail_count = 0;

	// A released request leaves no acknowledge behind
	a_dtack_needs_as: assert property (@(posedge MCLK) disable iff (reset)
		!m_as |=> !m_dtack)
	else begin
		$error("m_dtack still high after m_as was released");
		fail_count++;
	end

	a_zack_needs_req: assert property (@(posedge MCLK) disable iff (reset)
		!z_req |=> !z_ack)
	else begin
		$error("z_ack still high after z_req was released");
		fail_count++;
	end

	// New ROM request only once the previous one was answered
	a_rom_toggle: assert property (@(posedge MCLK) disable iff (reset)
		(rom_req != $past(rom_req)) |-> ($past(rom_ack) == $past(rom_req)))
	else begin
		$error("rom_req toggled while a ROM access was pending");
		fail_count++;
	end

	a_reset_quiet: assert property (@(posedge MCLK)
		$past(reset) |-> (!z80_busreq && !z80_reset_n && !m_dtack))
	else begin
		$error("control outputs or m_dtack not low during reset");
		fail_count++;
	end

endmodule

bind bus_system bus_system_asserts u_asserts (
	.MCLK        (MCLK),
	.reset       (reset),
	.m_as        (m_as),
	.m_dtack     (m_dtack),
	.z_req       (z_req),
	.z_ack       (z_ack),
	.rom_req     (rom_req),
	.rom_ack     (rom_ack),
	.z80_busreq  (z80_busreq),
	.z80_reset_n (z80_reset_n)
);

`default_nettype wire

// ==== bus_system.sv ====
// Top level joining the main-bus controller, work RAM, ROM mapper and sound bus
`timescale 1ns/1ns
`default_nettype none

module bus_system #(
	parameter int unsigned ROM_SIZE = 32'h40_0000,
	parameter int          RAM_AW   = 15
) (
	input  logic                       MCLK,
	input  logic                       reset,
	input  logic                       m_as,
	input  logic [bus_pkg::MA_W:1]     m_addr,
	input  logic [bus_pkg::MD_W-1:0]   m_wdata,
	input  logic                       m_rnw,
	input  logic                       m_uds,
	input  logic                       m_lds,
	output logic [bus_pkg::MD_W-1:0]   m_rdata,
	output logic                       m_dtack,
	input  logic                       z_req,
	input  logic [15:0]                z_addr,
	input  logic [7:0]                 z_wdata,
	input  logic                       z_wr,
	output logic [7:0]                 z_rdata,
	output logic                       z_ack,
	output logic [bus_pkg::ROM_AW:1]   rom_addr,
	input  logic [bus_pkg::MD_W-1:0]   rom_data,
	output logic                       rom_req,
	input  logic                       rom_ack,
	output logic                       z80_busreq,
	output logic                       z80_reset_n
);

	logic                       z_local;
	logic                       z_req_zb;
	logic                       z_req_mb;
	logic [bus_pkg::MA_W:1]     bus_addr;
	logic [bus_pkg::MD_W-1:0]   bus_wdata;
	logic                       bus_rnw;
	logic                       bus_uds;
	logic                       bank_wr;
	logic                       ram_we_u;
	logic                       ram_we_l;
	logic [bus_pkg::MD_W-1:0]   ram_rdata;
	logic                       zbus_sel;
	logic                       zbus_done;
	logic [7:0]                 zbus_rdata;
	logic                       zbus_free;
	logic [bus_pkg::BAR_W-1:0]  bar;
	logic [bus_pkg::ZA_W-1:0]   m_zaddr;
	logic [7:0]                 m_zdata;
	logic                       zb_ack;
	logic [7:0]                 zb_rdata;
	logic                       z_mack;
	logic [7:0]                 z_mrdata;

	// ------------------------------------------------------------------
	// Sound-CPU steering, 0000-7EFF stays local
	// ------------------------------------------------------------------
	assign z_local  = ~z_addr[15] & ~&z_addr[14:8];
	assign z_req_zb = z_req & z_local;
	assign z_req_mb = z_req & ~z_local;

	assign z_ack   = zb_ack | z_mack;
	assign z_rdata = zb_ack ? zb_rdata : z_mrdata;

	// Main-bus view of the sound bus, upper lane at the even byte
	assign m_zaddr = {bus_addr[14:1], ~bus_uds};
	assign m_zdata = bus_uds ? bus_wdata[15:8] : bus_wdata[7:0];

	main_bus_ctrl #(
		.ROM_SIZE (ROM_SIZE)
	) u_main_bus_ctrl (
		.MCLK        (MCLK),
		.reset       (reset),
		.m_as        (m_as),
		.m_addr      (m_addr),
		.m_wdata     (m_wdata),
		.m_rnw       (m_rnw),
		.m_uds       (m_uds),
		.m_lds       (m_lds),
		.m_rdata     (m_rdata),
		.m_dtack     (m_dtack),
		.z_req       (z_req_mb),
		.z_addr      (z_addr),
		.z_wdata     (z_wdata),
		.z_wr        (z_wr),
		.z_mack      (z_mack),
		.z_mrdata    (z_mrdata),
		.bar         (bar),
		.rom_req     (rom_req),
		.rom_ack     (rom_ack),
		.rom_data    (rom_data),
		.ram_rdata   (ram_rdata),
		.ram_we_u    (ram_we_u),
		.ram_we_l    (ram_we_l),
		.bus_addr    (bus_addr),
		.bus_wdata   (bus_wdata),
		.bus_rnw     (bus_rnw),
		.bus_uds     (bus_uds),
		.bank_wr     (bank_wr),
		.zbus_sel    (zbus_sel),
		.zbus_done   (zbus_done),
		.zbus_rdata  (zbus_rdata),
		.zbus_free   (zbus_free),
		.z80_busreq  (z80_busreq),
		.z80_reset_n (z80_reset_n)
	);

	work_ram #(
		.RAM_AW (RAM_AW)
	) u_work_ram (
		.MCLK  (MCLK),
		.addr  (bus_addr[RAM_AW:1]),
		.wdata (bus_wdata),
		.we_u  (ram_we_u),
		.we_l  (ram_we_l),
		.rdata (ram_rdata)
	);

	rom_mapper #(
		.ROM_SIZE (ROM_SIZE)
	) u_rom_mapper (
		.MCLK      (MCLK),
		.reset     (reset),
		.addr      (bus_addr),
		.bank_wr   (bank_wr),
		.bank_data (bus_wdata[bus_pkg::BANK_W-1:0]),
		.rom_addr  (rom_addr)
	);

	zbus_arbiter u_zbus_arbiter (
		.MCLK       (MCLK),
		.reset      (reset),
		.zbus_sel   (zbus_sel),
		.m_zaddr    (m_zaddr),
		.m_zdata    (m_zdata),
		.m_zwrite   (~bus_rnw),
		.zbus_free  (zbus_free),
		.zbus_done  (zbus_done),
		.zbus_rdata (zbus_rdata),
		.z_req      (z_req_zb),
		.z_addr     (z_addr),
		.z_wdata    (z_wdata),
		.z_wr       (z_wr),
		.z_ack      (zb_ack),
		.z_rdata    (zb_rdata),
		.bar        (bar)
	);

endmodule

`default_nettype wire

// ==== main_bus_ctrl.sv ====
// Main-bus FSM, address decode, sound-CPU control register and ROM handshake
`timescale 1ns/1ns
`default_nettype none

module main_bus_ctrl #(
	parameter int unsigned ROM_SIZE = 32'h40_0000
) (
	input  logic                       MCLK,
	input  logic                       reset,
	input  logic                       m_as,
	input  logic [bus_pkg::MA_W:1]     m_addr,
	input  logic [bus_pkg::MD_W-1:0]   m_wdata,
	input  logic                       m_rnw,
	input  logic                       m_uds,
	input  logic                       m_lds,
	output logic [bus_pkg::MD_W-1:0]   m_rdata,
	output logic                       m_dtack,
	input  logic                       z_req,
	input  logic [15:0]                z_addr,
	input  logic [7:0]                 z_wdata,
	input  logic                       z_wr,
	output logic                       z_mack,
	output logic [7:0]                 z_mrdata,
	input  logic [bus_pkg::BAR_W-1:0]  bar,
	output logic                       rom_req,
	input  logic                       rom_ack,
	input  logic [bus_pkg::MD_W-1:0]   rom_data,
	input  logic [bus_pkg::MD_W-1:0]   ram_rdata,
	output logic                       ram_we_u,
	output logic                       ram_we_l,
	output logic [bus_pkg::MA_W:1]     bus_addr,
	output logic [bus_pkg::MD_W-1:0]   bus_wdata,
	output logic                       bus_rnw,
	output logic                       bus_uds,
	output logic                       bank_wr,
	output logic                       zbus_sel,
	input  logic                       zbus_done,
	input  logic [7:0]                 zbus_rdata,
	output logic                       zbus_free,
	output logic                       z80_busreq,
	output logic                       z80_reset_n
);

	bus_pkg::mbus_state_t       state;
	bus_pkg::msrc_t             msrc;
	logic [bus_pkg::MD_W-1:0]   data;
	logic                       bus_lds;
	logic                       dtack_q;
	logic                       mack_q;
	logic                       rom_hit;
	logic                       ram_hit;
	logic                       zbus_hit;
	logic                       ctrl_hit;
	logic                       bank_hit;
	logic                       ctrl_bit;

	// Acks drop together with the request
	assign m_dtack   = dtack_q & m_as;
	assign z_mack    = mack_q & z_req;
	assign zbus_free = z80_busreq & z80_reset_n;

	assign ram_we_u = (state == bus_pkg::MB_RAM_READ) & ~bus_rnw & bus_uds;
	assign ram_we_l = (state == bus_pkg::MB_RAM_READ) & ~bus_rnw & bus_lds;
	assign bank_wr  = (state == bus_pkg::MB_SELECT) & bank_hit & ~bus_rnw;

	// ------------------------------------------------------------------
	// Address decode
	// ------------------------------------------------------------------
	assign rom_hit  = (bus_addr[23:20] < bus_pkg::ROM_LIMIT_NIB) &&
		({bus_addr, 1'b0} < ROM_SIZE);
	assign ram_hit  = bus_addr[23:21] == bus_pkg::RAM_BASE_NIB;
	assign zbus_hit = bus_addr[23:16] == bus_pkg::ZBUS_PAGE;
	assign ctrl_hit = (bus_addr[23:12] == bus_pkg::CTRL_PAGE) && (bus_addr[7:1] == 7'd0);
	assign bank_hit = bus_addr[23:8] == bus_pkg::BANK_PAGE;

	// Bit 8 of the control page readback
	always_comb begin
		case (bus_addr[11:8])
		4'h1:    ctrl_bit = ~z80_busreq;
		4'h2:    ctrl_bit = z80_reset_n;
		default: ctrl_bit = 1'b0;
		endcase
	end

	// ------------------------------------------------------------------
	// Main-bus FSM
	// ------------------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state       <= bus_pkg::MB_IDLE;
			msrc        <= bus_pkg::SRC_NONE;
			dtack_q     <= 1'b0;
			mack_q      <= 1'b0;
			zbus_sel    <= 1'b0;
			rom_req     <= 1'b0;
			z80_busreq  <= 1'b0;
			z80_reset_n <= 1'b0;
		end else begin
			if (!m_as)
				dtack_q <= 1'b0;
			if (!z_req)
				mack_q <= 1'b0;

			case (state)
			bus_pkg::MB_IDLE: begin
				// Main port wins a tie
				if (m_as && !dtack_q) begin
					msrc      <= bus_pkg::SRC_MAIN;
					bus_addr  <= m_addr;
					bus_wdata <= m_wdata;
					bus_rnw   <= m_rnw;
					bus_uds   <= m_uds;
					bus_lds   <= m_lds;
					state     <= bus_pkg::MB_SELECT;
				end else if (z_req && !mack_q) begin
					msrc      <= bus_pkg::SRC_SOUND;
					// Banked window or the dead C000xx space for 7Fxx
					bus_addr  <= z_addr[15] ? {bar, z_addr[14:1]} : {16'hC000, z_addr[7:1]};
					bus_wdata <= {z_wdata, z_wdata};
					bus_rnw   <= ~z_wr;
					bus_uds   <= ~z_addr[0];
					bus_lds   <= z_addr[0];
					state     <= bus_pkg::MB_SELECT;
				end
			end

			bus_pkg::MB_SELECT: begin
				data  <= '0;
				state <= bus_pkg::MB_FINISH;
				if (rom_hit) begin
					if (bus_rnw) begin
						rom_req <= ~rom_req;
						state   <= bus_pkg::MB_ROM_READ;
					end
				end else if (ram_hit) begin
					state <= bus_pkg::MB_RAM_READ;
				end else if (zbus_hit) begin
					state <= bus_pkg::MB_ZBUS_PRE;
				end else if (ctrl_hit) begin
					data <= {7'd0, ctrl_bit, 8'd0};
					if (!bus_rnw && bus_uds) begin
						if (bus_addr[11:8] == 4'h1)
							z80_busreq <= bus_wdata[8];
						if (bus_addr[11:8] == 4'h2)
							z80_reset_n <= bus_wdata[8];
					end
				end
			end

			bus_pkg::MB_RAM_READ: begin
				data  <= ram_rdata;
				state <= bus_pkg::MB_FINISH;
			end

			bus_pkg::MB_ROM_READ:
				if (rom_req == rom_ack) begin
					data  <= rom_data;
					state <= bus_pkg::MB_FINISH;
				end

			bus_pkg::MB_ZBUS_PRE: begin
				zbus_sel <= 1'b1;
				state    <= bus_pkg::MB_ZBUS_READ;
			end

			bus_pkg::MB_ZBUS_READ:
				if (zbus_done) begin
					zbus_sel <= 1'b0;
					data     <= {zbus_rdata, zbus_rdata};
					state    <= bus_pkg::MB_FINISH;
				end

			bus_pkg::MB_FINISH: begin
				case (msrc)
				bus_pkg::SRC_MAIN: begin
					m_rdata <= data;
					dtack_q <= 1'b1;
				end
				bus_pkg::SRC_SOUND: begin
					// Odd sound address takes the low byte
					z_mrdata <= bus_lds ? data[7:0] : data[15:8];
					mack_q   <= 1'b1;
				end
				default: ;
				endcase
				state <= bus_pkg::MB_IDLE;
			end

			default:
				state <= bus_pkg::MB_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== zbus_arbiter.sv ====
// Sound bus arbiter with sound RAM and sound-CPU bank register
`timescale 1ns/1ns
`default_nettype none

module zbus_arbiter (
	input  logic                       MCLK,
	input  logic                       reset,
	input  logic                       zbus_sel,
	input  logic [bus_pkg::ZA_W-1:0]   m_zaddr,
	input  logic [7:0]                 m_zdata,
	input  logic                       m_zwrite,
	input  logic                       zbus_free,
	output logic                       zbus_done,
	output logic [7:0]                 zbus_rdata,
	input  logic                       z_req,
	input  logic [15:0]                z_addr,
	input  logic [7:0]                 z_wdata,
	input  logic                       z_wr,
	output logic                       z_ack,
	output logic [7:0]                 z_rdata,
	output logic [bus_pkg::BAR_W-1:0]  bar
);

	bus_pkg::zbus_state_t       state;
	logic                       from_main;
	logic [bus_pkg::ZA_W-1:0]   za;
	logic [7:0]                 zd;
	logic                       zwe;
	logic                       ack_q;
	logic                       local_req;
	logic [7:0]                 zram [8192];
	logic [7:0]                 zram_q;
	logic [7:0]                 zbus_di;

	assign local_req = z_req & ~z_addr[15];
	assign z_ack     = ack_q & local_req;

	// Only sound RAM answers, rest of the local space floats high
	assign zbus_di = za[14] ? 8'hFF : zram_q;

	// ------------------------------------------------------------------
	// Sound RAM 0000-1FFF, mirrored at 2000-3FFF
	// ------------------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (zwe && !za[14])
			zram[za[12:0]] <= zd;
		zram_q <= zram[za[12:0]];
	end

	// Bank register 6000-60FF, one bit per write, LSB first
	always_ff @(posedge MCLK) begin
		if (reset)
			bar <= '0;
		else if (zwe && za[14:8] == 7'h60)
			bar <= {zd[0], bar[bus_pkg::BAR_W-1:1]};
	end

	// ------------------------------------------------------------------
	// Arbiter FSM, main bus first
	// ------------------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state     <= bus_pkg::ZB_IDLE;
			from_main <= 1'b0;
			zwe       <= 1'b0;
			zbus_done <= 1'b0;
			ack_q     <= 1'b0;
		end else begin
			zwe <= 1'b0;
			if (!zbus_sel)
				zbus_done <= 1'b0;
			if (!local_req)
				ack_q <= 1'b0;

			case (state)
			bus_pkg::ZB_IDLE: begin
				if (zbus_sel && !zbus_done) begin
					za        <= m_zaddr;
					zd        <= m_zdata;
					// Main-bus writes land only while the sound CPU is parked
					zwe       <= m_zwrite & zbus_free;
					from_main <= 1'b1;
					state     <= bus_pkg::ZB_READ;
				end else if (local_req && !ack_q) begin
					za        <= z_addr[14:0];
					zd        <= z_wdata;
					zwe       <= z_wr;
					from_main <= 1'b0;
					state     <= bus_pkg::ZB_READ;
				end
			end

			bus_pkg::ZB_READ:
				state <= bus_pkg::ZB_FINISH;

			bus_pkg::ZB_FINISH: begin
				if (from_main) begin
					zbus_rdata <= zbus_free ? zbus_di : 8'hFF;
					zbus_done  <= 1'b1;
				end else begin
					z_rdata <= zbus_di;
					ack_q   <= 1'b1;
				end
				state <= bus_pkg::ZB_IDLE;
			end

			default:
				state <= bus_pkg::ZB_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rom_mapper.sv ====
// ROM bank registers and main-bus to ROM address translation
`timescale 1ns/1ns
`default_nettype none

module rom_mapper #(
	parameter int unsigned ROM_SIZE = 32'h40_0000
) (
	input  logic                        MCLK,
	input  logic                        reset,
	input  logic [bus_pkg::MA_W:1]      addr,
	input  logic                        bank_wr,
	input  logic [bus_pkg::BANK_W-1:0]  bank_data,
	output logic [bus_pkg::ROM_AW:1]    rom_addr
);

	// Banking only exists on carts above 2 MB
	localparam logic BANK_EN = (ROM_SIZE > 32'h20_0000);

	logic [bus_pkg::BANK_W-1:0] bank_reg [8];
	logic                       banked;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			banked <= 1'b0;
			for (int i = 0; i < 8; i++)
				bank_reg[i] <= i[bus_pkg::BANK_W-1:0];
		end else if (bank_wr && BANK_EN && addr[3:1] != 3'd0) begin
			// Slot 0 is fixed, A130F3 maps to slot 1
			bank_reg[addr[3:1]] <= bank_data;
			banked <= 1'b1;
		end
	end

	// 512 KB pages selected by bits 21:19
	always_comb begin
		if (banked)
			rom_addr = {{(bus_pkg::ROM_AW - bus_pkg::BANK_W - 18){1'b0}},
				bank_reg[addr[21:19]], addr[18:1]};
		else
			rom_addr = {{(bus_pkg::ROM_AW - bus_pkg::MA_W){1'b0}}, addr};
	end

endmodule

`default_nettype wire

// ==== work_ram.sv ====
// Main work RAM with two byte lanes and registered read
`timescale 1ns/1ns
`default_nettype none

module work_ram #(
	parameter int RAM_AW = 15
) (
	input  logic              MCLK,
	input  logic [RAM_AW-1:0] addr,
	input  logic [15:0]       wdata,
	input  logic              we_u,
	input  logic              we_l,
	output logic [15:0]       rdata
);

	logic [7:0] mem_u [2**RAM_AW];
	logic [7:0] mem_l [2**RAM_AW];

	// Lanes write independently
	always_ff @(posedge MCLK) begin
		if (we_u)
			mem_u[addr] <= wdata[15:8];
		if (we_l)
			mem_l[addr] <= wdata[7:0];
		rdata <= {mem_u[addr], mem_l[addr]};
	end

endmodule

`default_nettype wire

// ==== bus_pkg.sv ====
// Bus widths, address map constants and state enums for the main-bus core
`default_nettype none

package bus_pkg;

	// ------------------------------------------------------------------
	// Widths
	// ------------------------------------------------------------------
	// Main-bus word address, byte address bits 23:1
	localparam int MA_W   = 23;
	localparam int MD_W   = 16;
	// ROM word address
	localparam int ROM_AW = 24;
	localparam int ZA_W   = 15;
	localparam int BANK_W = 5;
	// Sound-CPU window base, main address bits 23:15
	localparam int BAR_W  = 9;

	// ------------------------------------------------------------------
	// Address map
	// ------------------------------------------------------------------
	// Work RAM E00000-FFFFFF, byte address bits 23:21
	localparam logic [2:0]  RAM_BASE_NIB  = 3'h7;
	// ZBUS window A00000-A0FFFF
	localparam logic [7:0]  ZBUS_PAGE     = 8'hA0;
	// Sound-CPU control A11100 and A11200
	localparam logic [11:0] CTRL_PAGE     = 12'hA11;
	// ROM bank registers A130F3-A130FF
	localparam logic [15:0] BANK_PAGE     = 16'hA130;
	// ROM region ends below A00000
	localparam logic [3:0]  ROM_LIMIT_NIB = 4'hA;

	typedef enum logic [2:0] {
		MB_IDLE,
		MB_SELECT,
		MB_RAM_READ,
		MB_ROM_READ,
		MB_ZBUS_PRE,
		MB_ZBUS_READ,
		MB_FINISH
	} mbus_state_t;

	typedef enum logic [1:0] {
		SRC_NONE,
		SRC_MAIN,
		SRC_SOUND
	} msrc_t;

	typedef enum logic [1:0] {
		ZB_IDLE,
		ZB_READ,
		ZB_FINISH
	} zbus_state_t;

endpackage

`default_nettype wire
